//--- Bender.yml
package:
  name: pinball_decoder

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pinball_pkg.sv
      - bulk_match_stage.sv
      - boundary_match_stage.sv
      - pinball_decoder.sv
  - target: test
    include_dirs:
      - .
    files:
      - pinball_sva.sv
      - tb_pinball.sv

//--- boundary_match_stage.sv
`timescale 1ns/10ps

`include "pinball_params.svh"

module boundary_match_stage
    import pinball_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      valid_in,
    input  syndrome_t syndrome_in,
    input  corr_t     corr_in,
    output logic      valid_out,
    output logic      complex_out,
    output corr_t     corrections_out
);

    localparam int CODE_DISTANCE = `PINBALL_CODE_DISTANCE;
    localparam int NUM_ROWS      = `PINBALL_NUM_ROWS;
    localparam int NUM_COLS      = `PINBALL_NUM_COLS;

    // One edge ancilla per row
    syndrome_t clr_part [NUM_ROWS];
    corr_t     tgl_part [NUM_ROWS];

    syndrome_t clr_mask;
    corr_t     tgl_mask;

    // What is left after the boundary matches
    syndrome_t residual;

    ////////////////////////////////////////////////////////////
    // Edge matching
    ////////////////////////////////////////////////////////////

    for (genvar r = 0; r < NUM_ROWS; r++) begin : g_edge
        // Even rows use the right edge, odd rows the left edge
        localparam bit EVEN = (r % 2) == 0;
        localparam int COL = EVEN ? NUM_COLS - 1 : 0;

        // Right edge touches d[r][D-1], left edge touches d[r-1][0]
        localparam int DAT_I = EVEN ? r : r - 1;
        localparam int DAT_J = EVEN ? CODE_DISTANCE - 1 : 0;

        localparam syndrome_t ANC_BIT = syndrome_t'(1) << syn_idx(r, COL);
        localparam corr_t DATA_BIT = corr_t'(1) << corr_idx(DAT_I, DAT_J);

        // Defect on the edge ancilla
        logic hit;

        assign hit = syndrome_in[syn_idx(r, COL)];

        // Paired with the virtual boundary defect
        assign clr_part[r] = hit ? ANC_BIT : '0;
        assign tgl_part[r] = hit ? DATA_BIT : '0;
    end

    always_comb begin
        clr_mask = '0;
        tgl_mask = '0;
        for (int k = 0; k < NUM_ROWS; k++) begin
            clr_mask = clr_mask | clr_part[k];
            tgl_mask = tgl_mask | tgl_part[k];
        end
    end

    // Anything still set here could not be matched
    assign residual = syndrome_in & ~clr_mask;

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            complex_out     <= 1'b0;
            corrections_out <= '0;
        end else if (valid_in) begin
            complex_out     <= |residual;
            corrections_out <= corr_in ^ tgl_mask;
        end
    end

endmodule

//--- bulk_match_stage.sv
`timescale 1ns/10ps

`include "pinball_params.svh"

module bulk_match_stage
    import pinball_pkg::*;
#(
    parameter int direction = `PINBALL_DIR_TOP_RIGHT
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      valid_in,
    input  syndrome_t syndrome_in,
    input  corr_t     corr_in,
    output logic      valid_out,
    output syndrome_t syndrome_out,
    output corr_t     corr_out
);

    localparam int CODE_DISTANCE = `PINBALL_CODE_DISTANCE;
    localparam int NUM_ROWS      = `PINBALL_NUM_ROWS;
    localparam int NUM_COLS      = `PINBALL_NUM_COLS;

    // Centers sit on the odd ancilla rows only
    localparam int NUM_SITES = (NUM_ROWS / 2) * NUM_COLS;

    // Upward directions look at row r-1, downward ones at r+1
    localparam bit GO_UP = (direction == `PINBALL_DIR_TOP_RIGHT) ||
                           (direction == `PINBALL_DIR_TOP_LEFT);
    // Right-leaning directions keep the column, left ones step back one
    localparam bit GO_RIGHT = (direction == `PINBALL_DIR_TOP_RIGHT) ||
                              (direction == `PINBALL_DIR_BOTTOM_RIGHT);

    // Per-site contributions, merged below
    syndrome_t clr_part [NUM_SITES];
    corr_t     tgl_part [NUM_SITES];

    // Merged masks for the whole grid
    syndrome_t clr_mask;
    corr_t     tgl_mask;

    ////////////////////////////////////////////////////////////
    // Pairing pattern
    ////////////////////////////////////////////////////////////

    for (genvar rr = 0; rr < NUM_ROWS / 2; rr++) begin : g_row
        for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
            // Center ancilla row
            localparam int R = 2 * rr + 1;
            // Site number
            localparam int K = rr * NUM_COLS + c;

            // Diagonal neighbor of the center
            localparam int NBR_R = GO_UP ? R - 1 : R + 1;
            localparam int NBR_C = GO_RIGHT ? c : c - 1;

            // Data qubit that sits between center and neighbor
            localparam int DAT_I = GO_UP ? R - 1 : R;
            localparam int DAT_J = GO_RIGHT ? 2 * c + 1 : 2 * c;

            // Edge sites have no neighbor in this direction
            localparam bit HAS_PAIR = (NBR_R < NUM_ROWS) && (NBR_C >= 0) &&
                                      (DAT_I < CODE_DISTANCE);

            if (HAS_PAIR) begin : g_pair
                localparam syndrome_t PAIR_MASK =
                    (syndrome_t'(1) << syn_idx(R, c)) |
                    (syndrome_t'(1) << syn_idx(NBR_R, NBR_C));
                localparam corr_t DATA_BIT = corr_t'(1) << corr_idx(DAT_I, DAT_J);

                // Both defects present, so they pair up
                logic hit;

                assign hit = syndrome_in[syn_idx(R, c)] &
                             syndrome_in[syn_idx(NBR_R, NBR_C)];

                assign clr_part[K] = hit ? PAIR_MASK : '0;
                assign tgl_part[K] = hit ? DATA_BIT : '0;
            end else begin : g_none
                // Center passes through untouched
                assign clr_part[K] = '0;
                assign tgl_part[K] = '0;
            end
        end
    end

    // Sites never share an ancilla, so a plain OR merge is safe
    always_comb begin
        clr_mask = '0;
        tgl_mask = '0;
        for (int k = 0; k < NUM_SITES; k++) begin
            clr_mask = clr_mask | clr_part[k];
            tgl_mask = tgl_mask | tgl_part[k];
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////////////////

    // Valid follows the input on every edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // Residual and accumulated corrections load with a valid item
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            syndrome_out <= '0;
            corr_out     <= '0;
        end else if (valid_in) begin
            // Matched defects are cleared
            syndrome_out <= syndrome_in & ~clr_mask;
            // New corrections toggle onto the running word
            corr_out     <= corr_in ^ tgl_mask;
        end
    end

endmodule

//--- pinball_decoder.sv
`timescale 1ns/10ps

`include "pinball_params.svh"

module pinball_decoder
    import pinball_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      valid_in,
    input  syndrome_t syndrome_in,
    output logic      valid_out,
    output logic      complex_out,
    output corr_t     corrections_out
);

    // Stage 1 -> 2
    logic      tr_valid;
    syndrome_t tr_syndrome;
    corr_t     tr_corr;

    // Stage 2 -> 3
    logic      br_valid;
    syndrome_t br_syndrome;
    corr_t     br_corr;

    // Stage 3 -> 4
    logic      bl_valid;
    syndrome_t bl_syndrome;
    corr_t     bl_corr;

    // Stage 4 -> boundary
    logic      tl_valid;
    syndrome_t tl_syndrome;
    corr_t     tl_corr;

    ////////////////////////////////////////////////////////////
    // Bulk matching chain
    ////////////////////////////////////////////////////////////

    // First stage starts from an empty correction word
    bulk_match_stage #(
        .direction (`PINBALL_DIR_TOP_RIGHT)
    ) u_top_right (
        .clk          (clk),
        .rstn         (rstn),
        .valid_in     (valid_in),
        .syndrome_in  (syndrome_in),
        .corr_in      ('0),
        .valid_out    (tr_valid),
        .syndrome_out (tr_syndrome),
        .corr_out     (tr_corr)
    );

    bulk_match_stage #(
        .direction (`PINBALL_DIR_BOTTOM_RIGHT)
    ) u_bottom_right (
        .clk          (clk),
        .rstn         (rstn),
        .valid_in     (tr_valid),
        .syndrome_in  (tr_syndrome),
        .corr_in      (tr_corr),
        .valid_out    (br_valid),
        .syndrome_out (br_syndrome),
        .corr_out     (br_corr)
    );

    bulk_match_stage #(
        .direction (`PINBALL_DIR_BOTTOM_LEFT)
    ) u_bottom_left (
        .clk          (clk),
        .rstn         (rstn),
        .valid_in     (br_valid),
        .syndrome_in  (br_syndrome),
        .corr_in      (br_corr),
        .valid_out    (bl_valid),
        .syndrome_out (bl_syndrome),
        .corr_out     (bl_corr)
    );

    bulk_match_stage #(
        .direction (`PINBALL_DIR_TOP_LEFT)
    ) u_top_left (
        .clk          (clk),
        .rstn         (rstn),
        .valid_in     (bl_valid),
        .syndrome_in  (bl_syndrome),
        .corr_in      (bl_corr),
        .valid_out    (tl_valid),
        .syndrome_out (tl_syndrome),
        .corr_out     (tl_corr)
    );

    // Leftover edge defects go to the boundary
    boundary_match_stage u_boundary (
        .clk             (clk),
        .rstn            (rstn),
        .valid_in        (tl_valid),
        .syndrome_in     (tl_syndrome),
        .corr_in         (tl_corr),
        .valid_out       (valid_out),
        .complex_out     (complex_out),
        .corrections_out (corrections_out)
    );

endmodule

//--- pinball_params.svh
`ifndef PINBALL_PARAMS_SVH
`define PINBALL_PARAMS_SVH

// Surface code distance
`define PINBALL_CODE_DISTANCE 5

// Ancilla grid: one row more than the distance, (d-1)/2 ancillas per row
`define PINBALL_NUM_ROWS (`PINBALL_CODE_DISTANCE + 1)
`define PINBALL_NUM_COLS ((`PINBALL_CODE_DISTANCE - 1) / 2)

// Pairing direction codes for the bulk stages
`define PINBALL_DIR_TOP_RIGHT    0
`define PINBALL_DIR_BOTTOM_RIGHT 1
`define PINBALL_DIR_BOTTOM_LEFT  2
`define PINBALL_DIR_TOP_LEFT     3

`endif

//--- pinball_pkg.sv
package pinball_pkg;

`include "pinball_params.svh"

    // Flattened widths of the ancilla grid and the data qubit grid
    localparam int SYN_W  = `PINBALL_NUM_ROWS * `PINBALL_NUM_COLS;
    localparam int CORR_W = `PINBALL_CODE_DISTANCE * `PINBALL_CODE_DISTANCE;

    // One bit per ancilla, row major
    typedef logic [SYN_W-1:0] syndrome_t;

    // One bit per data qubit, row major
    typedef logic [CORR_W-1:0] corr_t;

    // Bit position of ancilla (row, col) in a syndrome_t
    function automatic int syn_idx(input int row, input int col);
        return row * `PINBALL_NUM_COLS + col;
    endfunction

    // Bit position of data qubit (row, col) in a corr_t
    function automatic int corr_idx(input int row, input int col);
        return row * `PINBALL_CODE_DISTANCE + col;
    endfunction

endpackage

//--- pinball_sva.sv
`timescale 1ns/10ps

module pinball_sva
    import pinball_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  valid_in,
    input logic  valid_out,
    input logic  complex_out,
    input corr_t corrections_out
);

    // Four bulk stages plus the boundary stage
    localparam int LATENCY = 5;

    ////////////////////////////////////////////////////////////
    // Reset
    ////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (
        @(posedge clk) !rstn |-> !valid_out
    ) else $error("valid_out high during reset");

    ////////////////////////////////////////////////////////////
    // Pipeline latency
    ////////////////////////////////////////////////////////////

    // Every accepted item comes out exactly five cycles later
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        valid_in |-> ##LATENCY valid_out
    ) else $error("valid_in not followed by valid_out after 5 cycles");

    // No output without a matching input
    a_no_stray_out: assert property (
        @(posedge clk) disable iff (!rstn)
        valid_out |-> $past(valid_in, LATENCY)
    ) else $error("valid_out without valid_in 5 cycles before");

    ////////////////////////////////////////////////////////////
    // Output data
    ////////////////////////////////////////////////////////////

    a_known_out: assert property (
        @(posedge clk) disable iff (!rstn)
        valid_out |-> !$isunknown({corrections_out, complex_out})
    ) else $error("unknown bits on decoder outputs");

endmodule

bind pinball_decoder pinball_sva sva_i (
    .clk             (clk),
    .rstn            (rstn),
    .valid_in        (valid_in),
    .valid_out       (valid_out),
    .complex_out     (complex_out),
    .corrections_out (corrections_out)
);

//--- src.f
+incdir+.
pinball_pkg.sv
bulk_match_stage.sv
boundary_match_stage.sv
pinball_decoder.sv
pinball_sva.sv
tb_pinball.sv

//--- tb_pinball.sv
`timescale 1ns/10ps

module tb_pinball
    import pinball_pkg::*;
();

    localparam int NUM_ENTRIES = 12;
    localparam int CLK_PERIOD  = 40;
    // One cycle per stage, five stages
    localparam int LATENCY     = 5;

    logic      clk = 1'b0;
    logic      rstn;
    logic      valid_in;
    syndrome_t syndrome_in;
    logic      valid_out;
    logic      complex_out;
    corr_t     corrections_out;

    // Stimulus and expected results, one row per item
    syndrome_t stim_syn [NUM_ENTRIES];
    corr_t     exp_corr [NUM_ENTRIES];
    logic      exp_cplx [NUM_ENTRIES];
    // Idle cycles after each item, zero means back to back
    int        idle_gap [NUM_ENTRIES];

    int cycle_cnt   = 0;
    int checked_cnt = 0;
    bit table_ready = 1'b0;

    // Cycle at which each in-flight item was driven
    int drive_cycle_q [$];

    ////////////////////////////////////////////////////////////
    // DUT, clock and cycle count
    ////////////////////////////////////////////////////////////

    pinball_decoder dut_i (
        .clk             (clk),
        .rstn            (rstn),
        .valid_in        (valid_in),
        .syndrome_in     (syndrome_in),
        .valid_out       (valid_out),
        .complex_out     (complex_out),
        .corrections_out (corrections_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////////////////////////////////////////////
    // Table
    ////////////////////////////////////////////////////////////

    task automatic set_entry(input int idx, input syndrome_t syn, input corr_t corr,
                             input logic cplx, input int gap);
        stim_syn[idx] = syn;
        exp_corr[idx] = corr;
        exp_cplx[idx] = cplx;
        idle_gap[idx] = gap;
    endtask

    // Ancilla (r,c) is bit 2r+c, data d[i][j] is bit 5i+j
    task automatic load_table();
        // Empty syndrome
        set_entry(0,  12'h000, 25'h0000000, 1'b0, 3);
        // Top right, (1,0)+(0,0) gives d[0][1]
        set_entry(1,  12'h005, 25'h0000002, 1'b0, 0);
        // Bottom right, (1,1)+(2,1) gives d[1][3]
        set_entry(2,  12'h028, 25'h0000100, 1'b0, 0);
        // Bottom left, (1,1)+(2,0) gives d[1][2]
        set_entry(3,  12'h018, 25'h0000080, 1'b0, 1);
        // Top left, (3,1)+(2,0) gives d[2][2]
        set_entry(4,  12'h090, 25'h0001000, 1'b0, 0);
        // Right edge (0,1) gives d[0][4]
        set_entry(5,  12'h002, 25'h0000010, 1'b0, 0);
        // Left edge (3,0) gives d[2][0]
        set_entry(6,  12'h040, 25'h0000400, 1'b0, 2);
        // Lone interior (2,0), nothing can take it
        set_entry(7,  12'h010, 25'h0000000, 1'b1, 0);
        // Top right d[0][1], top left (5,1)+(4,0) d[4][2]
        // plus edges (0,1) d[0][4] and (2,1) d[2][4]
        set_entry(8,  12'h927, 25'h0404012, 1'b0, 0);
        // Top right grabs (1,0) first, so (2,0) is left over
        set_entry(9,  12'h015, 25'h0000002, 1'b1, 0);
        // Left edge (5,0) gives d[4][0]
        set_entry(10, 12'h400, 25'h0100000, 1'b0, 1);
        // Top right, (5,1)+(4,1) gives d[4][3]
        set_entry(11, 12'hA00, 25'h0800000, 1'b0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // Check task and output monitor
    ////////////////////////////////////////////////////////////

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Outputs are sampled mid-cycle, well away from the driving edge
    always @(negedge clk) begin : monitor
        int drv;
        if (valid_out !== 1'b0) begin
            if (drive_cycle_q.size() == 0) begin
                $display("Error: valid_out high at cycle %0d with no item in flight",
                         cycle_cnt);
                $display("Simulation FAILED");
                $fatal(1, "unexpected output");
            end else begin
                drv = drive_cycle_q.pop_front();
                check_equal("latency", LATENCY, cycle_cnt - drv);
                check_equal("corrections_out", exp_corr[checked_cnt], corrections_out);
                check_equal("complex_out", exp_cplx[checked_cnt], complex_out);
                checked_cnt++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////

    initial begin : watchdog
        int limit_cycles;
        int k;
        wait (table_ready);
        limit_cycles = NUM_ENTRIES + LATENCY + 10;
        for (k = 0; k < NUM_ENTRIES; k++) begin
            limit_cycles += idle_gap[k];
        end
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: not every item came out within %0d cycles", limit_cycles);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin : driver
        int i;
        int g;
        rstn        = 1'b0;
        valid_in    = 1'b0;
        syndrome_in = '0;
        load_table();
        table_ready = 1'b1;

        // Reset held for three cycles
        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;

        for (i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            #2;
            valid_in    = 1'b1;
            syndrome_in = stim_syn[i];
            drive_cycle_q.push_back(cycle_cnt);
            for (g = 0; g < idle_gap[i]; g++) begin
                @(posedge clk);
                #2;
                valid_in    = 1'b0;
                // Junk on the bus while idle must not reach any result
                syndrome_in = '1;
            end
        end
        @(posedge clk);
        #2;
        valid_in    = 1'b0;
        syndrome_in = '0;

        // Wait for the pipeline to drain, then look for stray pulses
        wait (checked_cnt == NUM_ENTRIES);
        repeat (2) @(posedge clk);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
